// ==== logic/fencei_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i completion path settings
// widths and limits shared by the writeback fence.i logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FENCEI_SETTINGS_SVH
`define FENCEI_SETTINGS_SVH

// pc and data bus address width
`define FENCEI_ADDR_W 32

// data bus transactions allowed in flight
`define FENCEI_MAX_CREDITS 4

// credit count width, must hold 0 to FENCEI_MAX_CREDITS
`define FENCEI_CREDIT_W 3

`endif

// ==== logic/fencei_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i package
// instruction word views, opcode constants and state types
// for the writeback fence.i completion path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fencei_pkg;

  // MISC-MEM major opcode, shared by fence and fence.i
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  localparam logic [2:0] F3_FENCE  = 3'b000;
  localparam logic [2:0] F3_FENCEI = 3'b001;

  // one instruction word, read as I-type or as fence
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic [3:0]  fm;
      logic [3:0]  pred;
      logic [3:0]  succ;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } fence;
  } rv_instr_u;

  // single-entry store buffer occupancy
  typedef enum logic {
    WBUF_EMPTY = 1'b0,
    WBUF_FULL  = 1'b1
  } wbuf_state_e;

  // fence.i sequencing
  typedef enum logic [1:0] {
    FI_IDLE   = 2'b00,
    FI_DRAIN  = 2'b01,
    FI_FLUSH  = 2'b10,
    FI_BRANCH = 2'b11
  } fencei_state_e;

endpackage

// ==== logic/fencei_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i decoder
// spots fence.i in writeback and holds its branch target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "fencei_settings.svh"

module fencei_decoder import fencei_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wb_valid_i,
  input  rv_instr_u                 wb_instr_i,
  input  logic [`FENCEI_ADDR_W-1:0] wb_pc_i,
  input  logic                      capture_i,
  output logic                      is_fencei_o,
  output logic [`FENCEI_ADDR_W-1:0] target_pc_o
);

  localparam logic [`FENCEI_ADDR_W-1:0] PC_STEP = 4;

  logic                      misc_mem_op;
  logic                      fencei_f3;
  logic [`FENCEI_ADDR_W-1:0] next_pc;
  logic [`FENCEI_ADDR_W-1:0] target_q;

  // major opcode through the fence view
  assign misc_mem_op = (wb_instr_i.fence.opcode == OPC_MISC_MEM);

  // funct3 through the I-type view ignoring imm, rs1 and rd
  assign fencei_f3 = (wb_instr_i.itype.funct3 == F3_FENCEI);

  assign is_fencei_o = wb_valid_i && misc_mem_op && fencei_f3;

  // word aligned pc of the following instruction
  assign next_pc = {wb_pc_i[`FENCEI_ADDR_W-1:2], 2'b00} + PC_STEP;

  // target stays fixed while the flush is in progress
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      target_q <= '0;
    end else if (capture_i) begin
      target_q <= next_pc;
    end
  end

  assign target_pc_o = target_q;

endmodule

// ==== logic/lsu_credit_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data bus credit counter
// one credit per request in flight, returned by rvalid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "fencei_settings.svh"

module lsu_credit_counter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic spend_i,
  input  logic return_i,
  output logic credit_avail_o,
  output logic all_returned_o
);

  localparam logic [`FENCEI_CREDIT_W-1:0] MAX_CREDITS = `FENCEI_MAX_CREDITS;
  localparam logic [`FENCEI_CREDIT_W-1:0] ONE_CREDIT  = 1;

  logic [`FENCEI_CREDIT_W-1:0] credits_q;
  logic [`FENCEI_CREDIT_W-1:0] credits_d;

  always_comb begin
    credits_d = credits_q;
    // spend and return together leave the count alone
    if (spend_i && !return_i) begin
      credits_d = credits_q - ONE_CREDIT;
    end else if (return_i && !spend_i) begin
      credits_d = credits_q + ONE_CREDIT;
    end
  end

  // full pool after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= MAX_CREDITS;
    end else begin
      credits_q <= credits_d;
    end
  end

  assign credit_avail_o = (credits_q != '0);

  // nothing outstanding on the bus
  assign all_returned_o = (credits_q == MAX_CREDITS);

endmodule

// ==== logic/store_write_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store write buffer
// single entry that takes one store and sends it to the
// data bus once a credit is free
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "fencei_settings.svh"

module store_write_buffer import fencei_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // store port
  input  logic                      st_valid_i,
  input  logic [`FENCEI_ADDR_W-1:0] st_addr_i,
  input  logic [31:0]               st_data_i,
  output logic                      st_ready_o,

  input  logic                      store_hold_i,
  input  logic                      credit_avail_i,

  // data bus
  output logic                      data_req_o,
  output logic [`FENCEI_ADDR_W-1:0] data_addr_o,
  output logic [31:0]               data_wdata_o,
  input  logic                      data_gnt_i,

  output wbuf_state_e               wbuf_state_o
);

  wbuf_state_e               state_q;
  wbuf_state_e               state_d;
  logic [`FENCEI_ADDR_W-1:0] addr_q;
  logic [31:0]               wdata_q;
  logic                      store_accept;
  logic                      bus_done;

  // a full entry blocks new stores until it is granted
  assign st_ready_o   = (state_q == WBUF_EMPTY) && !store_hold_i;
  assign store_accept = st_valid_i && st_ready_o;

  assign data_req_o = (state_q == WBUF_FULL) && credit_avail_i && !store_hold_i;
  assign bus_done   = data_req_o && data_gnt_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WBUF_EMPTY: begin
        if (store_accept) begin
          state_d = WBUF_FULL;
        end
      end
      WBUF_FULL: begin
        if (bus_done) begin
          state_d = WBUF_EMPTY;
        end
      end
      default: state_d = WBUF_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WBUF_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // store payload
  always_ff @(posedge clk_i) begin
    if (store_accept) begin
      addr_q  <= st_addr_i;
      wdata_q <= st_data_i;
    end
  end

  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign wbuf_state_o = state_q;

endmodule

// ==== logic/fencei_ctrl_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i control FSM
// stalls writeback, drains pending stores, runs the flush
// request/acknowledge handshake, then retires and branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fencei_ctrl_fsm import fencei_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_valid_i,
  input  logic        is_fencei_i,
  input  wbuf_state_e wbuf_state_i,
  input  logic        all_returned_i,
  input  logic        flush_ack_i,
  output logic        capture_o,
  output logic        store_hold_o,
  output logic        flush_req_o,
  output logic        wb_ready_o,
  output logic        retire_o,
  output logic        branch_o
);

  fencei_state_e state_q;
  fencei_state_e state_d;
  logic          fencei_start;
  logic          drained;
  logic          stall_window;

  assign fencei_start = (state_q == FI_IDLE) && is_fencei_i;

  // buffer empty and every granted store answered
  assign drained = (wbuf_state_i == WBUF_EMPTY) && all_returned_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FI_IDLE: begin
        if (fencei_start) begin
          state_d = FI_DRAIN;
        end
      end
      FI_DRAIN: begin
        if (drained) begin
          state_d = FI_FLUSH;
        end
      end
      FI_FLUSH: begin
        // req is held until seen together with ack
        if (flush_ack_i) begin
          state_d = FI_BRANCH;
        end
      end
      FI_BRANCH: begin
        state_d = FI_IDLE;
      end
      default: state_d = FI_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FI_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // pc is stable in the entry cycle
  assign capture_o = fencei_start;

  // from the entry cycle up to the branch
  assign stall_window = fencei_start || (state_q == FI_DRAIN) || (state_q == FI_FLUSH);

  // a store still in the buffer must reach the bus to drain,
  // so the hold only bites on an empty entry
  assign store_hold_o = stall_window && (wbuf_state_i == WBUF_EMPTY);

  assign flush_req_o = (state_q == FI_FLUSH);
  assign branch_o    = (state_q == FI_BRANCH);

  always_comb begin
    wb_ready_o = 1'b0;
    retire_o   = 1'b0;
    case (state_q)
      FI_IDLE: begin
        // ordinary instructions pass straight through
        wb_ready_o = !is_fencei_i;
        retire_o   = wb_valid_i && !is_fencei_i;
      end
      FI_BRANCH: begin
        wb_ready_o = 1'b1;
        retire_o   = 1'b1;
      end
      default: begin
        wb_ready_o = 1'b0;
        retire_o   = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/fencei_unit_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i unit top level
// writeback fence.i completion: decoder, credit counter,
// store write buffer and control FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "fencei_settings.svh"

module fencei_unit_top import fencei_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // writeback stage
  input  logic                      wb_valid_i,
  input  rv_instr_u                 wb_instr_i,
  input  logic [`FENCEI_ADDR_W-1:0] wb_pc_i,
  output logic                      wb_ready_o,
  output logic                      retire_o,

  // store port
  input  logic                      st_valid_i,
  input  logic [`FENCEI_ADDR_W-1:0] st_addr_i,
  input  logic [31:0]               st_data_i,
  output logic                      st_ready_o,

  // data bus
  output logic                      data_req_o,
  output logic [`FENCEI_ADDR_W-1:0] data_addr_o,
  output logic [31:0]               data_wdata_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,

  // instruction side flush
  output logic                      flush_req_o,
  input  logic                      flush_ack_i,

  // branch to the instruction after fence.i
  output logic                      branch_o,
  output logic [`FENCEI_ADDR_W-1:0] branch_pc_o
);

  logic                      is_fencei;
  logic                      capture;
  logic [`FENCEI_ADDR_W-1:0] target_pc;
  logic                      credit_avail;
  logic                      all_returned;
  logic                      store_hold;
  wbuf_state_e               wbuf_state;

  fencei_decoder u_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_valid_i  (wb_valid_i),
    .wb_instr_i  (wb_instr_i),
    .wb_pc_i     (wb_pc_i),
    .capture_i   (capture),
    .is_fencei_o (is_fencei),
    .target_pc_o (target_pc)
  );

  // a credit is spent only by a granted request
  lsu_credit_counter u_credit_counter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .spend_i        (data_req_o && data_gnt_i),
    .return_i       (data_rvalid_i),
    .credit_avail_o (credit_avail),
    .all_returned_o (all_returned)
  );

  store_write_buffer u_write_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .st_valid_i     (st_valid_i),
    .st_addr_i      (st_addr_i),
    .st_data_i      (st_data_i),
    .st_ready_o     (st_ready_o),
    .store_hold_i   (store_hold),
    .credit_avail_i (credit_avail),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_gnt_i     (data_gnt_i),
    .wbuf_state_o   (wbuf_state)
  );

  fencei_ctrl_fsm u_ctrl_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wb_valid_i     (wb_valid_i),
    .is_fencei_i    (is_fencei),
    .wbuf_state_i   (wbuf_state),
    .all_returned_i (all_returned),
    .flush_ack_i    (flush_ack_i),
    .capture_o      (capture),
    .store_hold_o   (store_hold),
    .flush_req_o    (flush_req_o),
    .wb_ready_o     (wb_ready_o),
    .retire_o       (retire_o),
    .branch_o       (branch_o)
  );

  assign branch_pc_o = target_pc;

endmodule

// ==== tb/fencei_monitor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i protocol monitor
// watches the flush handshake, the branch pulse and the
// data bus credit usage without driving anything
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "fencei_settings.svh"

module fencei_monitor import fencei_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_valid_i,
  input  logic        wb_ready_i,
  input  logic        retire_i,
  input  logic        st_ready_i,
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  wbuf_state_e wbuf_state_i,
  input  logic        flush_req_i,
  input  logic        flush_ack_i,
  input  logic        branch_i,
  output logic        error_o
);

  // granted stores still waiting for rvalid
  int   outstanding;
  logic req_wait_q;
  logic flush_q;
  logic ack_q;

  task automatic flag(input string what);
    $display("monitor: %s at %0t ns", what, $time);
    error_o = 1'b1;
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding <= 0;
      req_wait_q  <= 1'b0;
      flush_q     <= 1'b0;
      ack_q       <= 1'b0;
      error_o     = 1'b0;
    end else begin
      if (data_rvalid_i && outstanding == 0) flag("rvalid with no granted store outstanding");
      if (data_req_i && outstanding >= `FENCEI_MAX_CREDITS) flag("data request with no credit left");
      if (req_wait_q && !data_req_i) flag("data request dropped before its grant");
      if (flush_req_i && (outstanding != 0 || wbuf_state_i != WBUF_EMPTY)) begin
        flag("flush request raised before the stores drained");
      end
      if (flush_req_i && data_req_i) flag("data request started during the flush");
      if (wb_valid_i && !wb_ready_i && st_ready_i) flag("store port open while writeback stalls");
      // req must hold until seen with ack, then drop
      if (flush_q && !ack_q && !flush_req_i) flag("flush request dropped without acknowledge");
      if (flush_q && ack_q && flush_req_i) flag("flush request held after acknowledge");
      if (branch_i != (flush_q && ack_q)) flag("branch pulse does not follow the acknowledge");
      if (branch_i && !(retire_i && wb_ready_i)) flag("branch without retire and ready");
      if (retire_i && !wb_ready_i) flag("retire while writeback is stalled");
      outstanding <= outstanding + int'(data_req_i && data_gnt_i) - int'(data_rvalid_i);
      req_wait_q  <= data_req_i && !data_gnt_i;
      flush_q     <= flush_req_i;
      ack_q       <= flush_ack_i;
    end
  end

endmodule

// ==== tb/fencei_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i unit testbench
// random stores and bus delays around fence.i sequences,
// checks retire, flush handshake and branch target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "fencei_settings.svh"

module fencei_tb import fencei_pkg::*; ();

  logic                      clk_i;
  logic                      rst_ni;
  logic                      wb_valid_i;
  rv_instr_u                 wb_instr_i;
  logic [`FENCEI_ADDR_W-1:0] wb_pc_i;
  logic                      wb_ready_o;
  logic                      retire_o;
  logic                      st_valid_i;
  logic                      st_ready_o;
  logic [`FENCEI_ADDR_W-1:0] st_addr_i;
  logic [31:0]               st_data_i;
  logic                      data_req_o;
  logic [`FENCEI_ADDR_W-1:0] data_addr_o;
  logic [31:0]               data_wdata_o;
  logic                      data_gnt_i;
  logic                      data_rvalid_i;
  logic                      flush_req_o;
  logic                      flush_ack_i;
  logic                      branch_o;
  logic [`FENCEI_ADDR_W-1:0] branch_pc_o;
  logic                      monitor_error;
  wbuf_state_e               wbuf_state;
  fencei_state_e             fsm_state;

  integer seed = 32'h681b_b0c1;
  integer st_seed;
  integer bus_seed;
  integer cycle;
  integer stores_accepted;
  logic   stores_on;
  // accepted stores as {addr, data} with the oldest first
  logic [63:0] sent_q[$];
  integer      rvalid_due[$];

  fencei_unit_top dut0 (.*);

  assign wbuf_state = dut0.wbuf_state;
  assign fsm_state  = dut0.u_ctrl_fsm.state_q;

  fencei_monitor monitor0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid_i),
    .wb_ready_i    (wb_ready_o),
    .retire_i      (retire_o),
    .st_ready_i    (st_ready_o),
    .data_req_i    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .wbuf_state_i  (wbuf_state),
    .flush_req_i   (flush_req_o),
    .flush_ack_i   (flush_ack_i),
    .branch_i      (branch_o),
    .error_o       (monitor_error)
  );

  always #5 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s (FSM %s) at %0t ns", why, fsm_state.name(), $time);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_addr(input string name, input logic [`FENCEI_ADDR_W-1:0] got, exp);
    if (got !== exp) fail_run($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_data(input string name, input logic [31:0] got, exp);
    if (got !== exp) fail_run($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_wbuf(input string name, input wbuf_state_e got, exp);
    if (got !== exp) fail_run($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) fail_run($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  // next word-aligned instruction after the fence.i
  function automatic logic [`FENCEI_ADDR_W-1:0] ref_branch_pc(
    input logic [`FENCEI_ADDR_W-1:0] pc);
    return (pc >> 2) * 4 + 4;
  endfunction

  always @(posedge monitor_error) begin
    fail_run("protocol monitor found a violation");
  end

  // bus model with random grant and late in-order rvalid that can use up every credit
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle = cycle + 1;
      if (data_req_o && data_gnt_i) begin
        if (sent_q.size() == 0) fail_run("data bus request with no store accepted");
        check_addr("data_addr_o", data_addr_o, sent_q[0][63:32]);
        check_data("data_wdata_o", data_wdata_o, sent_q[0][31:0]);
        void'(sent_q.pop_front());
        rvalid_due.push_back(cycle + 1 + ($random(bus_seed) & 15));
      end
      data_gnt_i <= (($random(bus_seed) & 3) != 0);
      if (rvalid_due.size() > 0 && rvalid_due[0] <= cycle) begin
        data_rvalid_i <= 1'b1;
        void'(rvalid_due.pop_front());
      end else begin
        data_rvalid_i <= 1'b0;
      end
    end
  end

  // store bursts held until accepted
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (st_valid_i && st_ready_o) begin
        sent_q.push_back({st_addr_i, st_data_i});
        stores_accepted = stores_accepted + 1;
      end
      if (!st_valid_i || st_ready_o) begin
        st_valid_i <= stores_on && (($random(st_seed) & 1) != 0);
        st_addr_i  <= $random(st_seed);
        st_data_i  <= $random(st_seed);
      end
    end
  end

  initial begin
    rv_instr_u                 instr;
    logic [`FENCEI_ADDR_W-1:0] pc;
    logic [`FENCEI_ADDR_W-1:0] exp_pc;
    int                        wait_cnt;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    wb_valid_i      = 1'b0;
    wb_instr_i      = '0;
    wb_pc_i         = '0;
    st_valid_i      = 1'b0;
    st_addr_i       = '0;
    st_data_i       = '0;
    data_gnt_i      = 1'b0;
    data_rvalid_i   = 1'b0;
    flush_ack_i     = 1'b0;
    stores_on       = 1'b0;
    cycle           = 0;
    stores_accepted = 0;
    st_seed         = seed + 1;
    bus_seed        = seed + 2;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("flush_req_o", flush_req_o, 1'b0);
    check_bit("branch_o", branch_o, 1'b0);
    check_bit("retire_o", retire_o, 1'b0);
    check_bit("data_req_o", data_req_o, 1'b0);
    check_wbuf("wbuf_state", wbuf_state, WBUF_EMPTY);
    check_bit("all_returned", dut0.all_returned, 1'b1);
    stores_on = 1'b1;
    for (int n = 0; n < 30; n++) begin
      // ordinary instructions with plain fences among them
      repeat (1 + ($random(seed) & 1)) begin
        @(posedge clk_i);
        instr = $random(seed);
        instr.itype.opcode = ($random(seed) & 1) ? OPC_MISC_MEM : 7'b0010011;
        if (instr.fence.opcode == OPC_MISC_MEM) instr.fence.funct3 = F3_FENCE;
        wb_valid_i <= 1'b1;
        wb_instr_i <= instr;
        wb_pc_i    <= $random(seed);
        @(negedge clk_i);
        check_bit("retire_o", retire_o, 1'b1);
        check_bit("wb_ready_o", wb_ready_o, 1'b1);
        check_bit("branch_o", branch_o, 1'b0);
      end
      // fence.i with random reserved fields and pc
      @(posedge clk_i);
      instr = $random(seed);
      instr.itype.opcode = OPC_MISC_MEM;
      instr.itype.funct3 = F3_FENCEI;
      pc     = $random(seed);
      exp_pc = ref_branch_pc(pc);
      wb_instr_i <= instr;
      wb_pc_i    <= pc;
      wait_cnt = 0;
      do begin
        @(negedge clk_i);
        check_bit("wb_ready_o", wb_ready_o, 1'b0);
        check_bit("retire_o", retire_o, 1'b0);
        wait_cnt++;
        if (wait_cnt > 200) fail_run("timeout waiting for the flush request");
      end while (!flush_req_o);
      // ack withheld for 0 to 5 cycles
      repeat (n % 6) begin
        @(negedge clk_i);
        check_bit("flush_req_o", flush_req_o, 1'b1);
        check_bit("wb_ready_o", wb_ready_o, 1'b0);
      end
      @(posedge clk_i);
      flush_ack_i <= 1'b1;
      @(negedge clk_i);
      check_bit("flush_req_o", flush_req_o, 1'b1);
      @(posedge clk_i);
      flush_ack_i <= 1'b0;
      @(negedge clk_i);
      check_bit("flush_req_o", flush_req_o, 1'b0);
      check_bit("branch_o", branch_o, 1'b1);
      check_bit("retire_o", retire_o, 1'b1);
      check_bit("wb_ready_o", wb_ready_o, 1'b1);
      check_addr("branch_pc_o", branch_pc_o, exp_pc);
      @(posedge clk_i);
      wb_valid_i <= 1'b0;
      @(negedge clk_i);
      check_bit("branch_o", branch_o, 1'b0);
      check_bit("retire_o", retire_o, 1'b0);
    end
    // let the last stores reach the bus and come back
    stores_on = 1'b0;
    wait_cnt  = 0;
    do begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > 200) fail_run("timeout waiting for the stores to drain");
    end while (st_valid_i || wbuf_state != WBUF_EMPTY || !dut0.all_returned);
    if (stores_accepted == 0) begin
      fail_run("the store port never accepted a store");
    end else if (sent_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_run("accepted stores never reached the data bus");
    end
  end

endmodule

// ==== sources.f ====
+incdir+logic
logic/fencei_pkg.sv
logic/fencei_decoder.sv
logic/lsu_credit_counter.sv
logic/store_write_buffer.sv
logic/fencei_ctrl_fsm.sv
logic/fencei_unit_top.sv
tb/fencei_monitor.sv
tb/fencei_tb.sv
